/* Makefile */
SRCS := $(wildcard verilog/*.sv tests/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_board_glue

obj_dir/Vtb_board_glue: sim.f $(SRCS)
	verilator --binary --timing -f sim.f --top-module tb_board_glue \
		-Mdir obj_dir -o Vtb_board_glue

run: obj_dir/Vtb_board_glue
	./obj_dir/Vtb_board_glue | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

/* sim.f */
verilog/board_pkg.sv
verilog/rst_sync.sv
verilog/boot_sel.sv
verilog/rtc_div.sv
verilog/fan_pwm.sv
verilog/pad_adapt.sv
verilog/board_glue_top.sv
tests/glue_checker.sv
tests/tb_board_glue.sv

/* tests/glue_checker.sv */
`timescale 1ns/100ps

module glue_checker (
  input logic                                soc_clk,
  input logic                                soc_rst_n_o,
  input logic [board_pkg::BootModeWidth-1:0] boot_mode_o,
  input logic                                rtc_o,
  input logic                                fan_pwm_o,
  input board_pkg::sd_pads_t                 sd_pads_o,
  input board_pkg::i2c_pads_t                i2c_pads_o,
  input logic [3:0]                          spi_sd_in_o,
  input logic                                i2c_scl_o,
  input logic                                i2c_sda_o
);

  import board_pkg::*;

  localparam int WaitLimit = 200;

  int    test_cnt = 0;
  int    err_cnt  = 0;
  int    err_at_start;
  string test_name;

  ////////////////////////////////////////////////////////////////////////////
  // Bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  task automatic begin_test(input string name);
    test_name    = name;
    err_at_start = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    if (err_cnt == err_at_start) begin
      $display("test %0d %s: ok", test_cnt, test_name);
    end else begin
      $display("test %0d %s: error", test_cnt, test_name);
    end
  endtask

  task automatic note_error(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic compare_val(input string what, input logic [31:0] exp,
                             input logic [31:0] got);
    if (exp !== got) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, what, exp, got);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic expect_reset_low();
    @(negedge soc_clk);
    compare_val("soc_rst_n_o asserted", 32'd0, 32'(soc_rst_n_o));
  endtask

  // Counts rising edges from release until the SoC reset goes high
  task automatic expect_release(input logic [31:0] edges);
    int n;
    n = 0;
    @(negedge soc_clk);
    while (!soc_rst_n_o && n < WaitLimit) begin
      @(posedge soc_clk);
      @(negedge soc_clk);
      n++;
    end
    if (!soc_rst_n_o) begin
      note_error("timeout waiting for the SoC reset to release");
    end else begin
      compare_val("reset release edges", edges, 32'(n));
    end
  endtask

  task automatic measure_rtc(input logic [31:0] periods, input logic [31:0] half);
    int   n;
    logic prev;
    n = 0;
    @(negedge soc_clk);
    while (!soc_rst_n_o && n < WaitLimit) begin
      @(negedge soc_clk);
      n++;
    end
    if (!soc_rst_n_o) begin
      note_error("timeout waiting for the SoC reset before the RTC check");
    end else begin
      compare_val("rtc_o after reset", 32'd0, 32'(rtc_o));
      prev = rtc_o;
      // First level lasts a full half period from release as well
      for (int p = 0; p < int'(periods); p++) begin
        n = 0;
        while (rtc_o == prev && n < WaitLimit) begin
          @(negedge soc_clk);
          n++;
        end
        if (rtc_o == prev) begin
          note_error("timeout waiting for rtc_o to toggle");
          break;
        end
        compare_val("rtc half period", half, 32'(n));
        prev = rtc_o;
      end
    end
  endtask

  task automatic measure_fan(input logic [31:0] highs);
    int n;
    n = 0;
    // Two periods so the new setting is surely in effect
    repeat (32) @(posedge soc_clk);
    for (int c = 0; c < 16; c++) begin
      @(negedge soc_clk);
      if (fan_pwm_o) begin
        n++;
      end
    end
    compare_val("fan pwm high cycles", highs, 32'(n));
  endtask

  // Switch path still shows the previous switch value one cycle in
  task automatic expect_boot(input logic sel, input logic [31:0] old_mode,
                             input logic [31:0] mode);
    if (!sel) begin
      @(posedge soc_clk);
      @(negedge soc_clk);
      compare_val("boot_mode_o one cycle after switch", old_mode, 32'(boot_mode_o));
      @(posedge soc_clk);
    end
    @(negedge soc_clk);
    compare_val("boot_mode_o", mode, 32'(boot_mode_o));
  endtask

  task automatic expect_sd(input logic [31:0] pads, input logic [31:0] sd_in);
    @(negedge soc_clk);
    compare_val("sd_pads_o", pads, 32'(sd_pads_o));
    compare_val("spi_sd_in_o", sd_in, 32'(spi_sd_in_o));
  endtask

  task automatic expect_i2c(input logic [31:0] pulls, input logic [31:0] lines);
    @(negedge soc_clk);
    compare_val("i2c_pads_o", pulls, 32'(i2c_pads_o));
    compare_val("i2c read-back", lines, 32'({i2c_scl_o, i2c_sda_o}));
  endtask

endmodule

/* tests/glue_testdata.txt */
# kind arg0 arg1 arg2 exp0 exp1, all hex; kinds 1 reset 2 rtc 3 fan 4 boot 5 sd 6 i2c
# reset: arg0 0 board 1 debug 2 test mode, exp0 edges to release
1 0 0 0 2 0
1 1 0 0 2 0
1 2 0 0 0 0
2 4 0 0 19 0
3 0 0 0 0 0
3 1 0 0 1 0
3 7 0 0 7 0
3 8 0 0 8 0
3 f 0 0 f 0
4 2 0 0 2 0
4 1 0 0 1 0
4 3 2 1 2 0
4 0 1 1 1 0
5 0000 0 0 7e 0
5 130f 1 0 0e 2
5 3fff 0 0 7e 0
5 2cf0 1 0 7e 2
5 1911 1 0 2e 2
5 0001 0 0 5e 0
6 0 3 0 0 3
6 5 0 0 3 0
6 f 2 0 0 2
6 4 1 0 2 1
6 1 3 0 1 3
6 a 0 0 0 0
6 6 2 0 2 2

/* tests/tb_board_glue.sv */
`timescale 1ns/100ps

module tb_board_glue;

  import board_pkg::*;

  logic                     soc_clk;
  logic                     rst_n;
  logic                     dbg_reset_i;
  logic [BootModeWidth-1:0] boot_switch_i;
  logic [BootModeWidth-1:0] boot_override_i;
  logic                     boot_override_sel_i;
  logic                     test_mode_i;
  logic [FanSetWidth-1:0]   fan_setting_i;
  spi_soc_t                 spi_soc_i;
  i2c_soc_t                 i2c_soc_i;
  logic                     sd_miso_pad_i;
  logic                     scl_pad_i;
  logic                     sda_pad_i;

  logic                     soc_rst_n_o;
  logic [BootModeWidth-1:0] boot_mode_o;
  logic                     rtc_o;
  logic                     fan_pwm_o;
  sd_pads_t                 sd_pads_o;
  i2c_pads_t                i2c_pads_o;
  logic [3:0]               spi_sd_in_o;
  logic                     i2c_scl_o;
  logic                     i2c_sda_o;

  int          fd;
  int          fields;
  string       line;
  logic [31:0] kind, arg0, arg1, arg2, exp0, exp1;
  logic [31:0] rnd;

  board_glue_top dut (.*);

  glue_checker chk (
    .soc_clk     ( soc_clk     ),
    .soc_rst_n_o ( soc_rst_n_o ),
    .boot_mode_o ( boot_mode_o ),
    .rtc_o       ( rtc_o       ),
    .fan_pwm_o   ( fan_pwm_o   ),
    .sd_pads_o   ( sd_pads_o   ),
    .i2c_pads_o  ( i2c_pads_o  ),
    .spi_sd_in_o ( spi_sd_in_o ),
    .i2c_scl_o   ( i2c_scl_o   ),
    .i2c_sda_o   ( i2c_sda_o   )
  );

  initial begin
    soc_clk = 1'b0;
    forever #5 soc_clk = ~soc_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-record stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_reset_case(input logic [31:0] variant, input logic [31:0] edges);
    chk.begin_test("reset release");
    @(posedge soc_clk);
    case (variant)
      32'd1: dbg_reset_i <= 1'b1;
      32'd2: begin
        test_mode_i <= 1'b1;
        rst_n       <= 1'b0;
      end
      default: rst_n <= 1'b0;
    endcase
    chk.expect_reset_low();
    repeat (2) @(posedge soc_clk);
    dbg_reset_i <= 1'b0;
    rst_n       <= 1'b1;
    chk.expect_release(edges);
    // Let the chain fill before leaving scan mode
    repeat (4) @(posedge soc_clk);
    test_mode_i <= 1'b0;
    chk.end_test();
  endtask

  task automatic run_record();
    logic [BootModeWidth-1:0] old_switch;
    @(posedge soc_clk);
    case (kind)
      32'd1: run_reset_case(arg0, exp0);
      32'd2: begin
        chk.begin_test("rtc divider");
        rst_n <= 1'b0;
        @(posedge soc_clk);
        rst_n <= 1'b1;
        chk.measure_rtc(arg0, exp0);
        chk.end_test();
      end
      32'd3: begin
        chk.begin_test("fan pwm");
        fan_setting_i <= arg0[FanSetWidth-1:0];
        chk.measure_fan(exp0);
        chk.end_test();
      end
      32'd4: begin
        chk.begin_test("boot mode");
        old_switch          = boot_switch_i;
        boot_switch_i       <= arg0[BootModeWidth-1:0];
        boot_override_i     <= arg1[BootModeWidth-1:0];
        boot_override_sel_i <= arg2[0];
        chk.expect_boot(arg2[0], 32'(old_switch), exp0);
        chk.end_test();
      end
      32'd5: begin
        chk.begin_test("sd spi map");
        spi_soc_i     <= arg0[13:0];
        sd_miso_pad_i <= arg1[0];
        chk.expect_sd(exp0, exp1);
        chk.end_test();
      end
      32'd6: begin
        chk.begin_test("i2c open drain");
        i2c_soc_i <= arg0[3:0];
        scl_pad_i <= arg1[1];
        sda_pad_i <= arg1[0];
        chk.expect_i2c(exp0, exp1);
        chk.end_test();
      end
      default: chk.note_error("unknown test kind in data file");
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rnd                 = $urandom(32'h349c_e6e1);
    rst_n               = 1'b0;
    dbg_reset_i         = 1'b0;
    boot_switch_i       = '0;
    boot_override_i     = '0;
    boot_override_sel_i = 1'b0;
    test_mode_i         = 1'b0;
    fan_setting_i       = '0;
    spi_soc_i           = '0;
    i2c_soc_i           = '0;
    sd_miso_pad_i       = 1'b0;
    scl_pad_i           = 1'b1;
    sda_pad_i           = 1'b1;

    fd = $fopen("tests/glue_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      $display("sim failed");
      $finish;
    end else begin
      chk.begin_test("power-on reset");
      repeat (3) @(posedge soc_clk);
      rst_n <= 1'b1;
      chk.expect_release(32'd2);
      chk.end_test();

      while ($fgets(line, fd) != 0) begin
        fields = 0;
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h", kind, arg0, arg1, arg2, exp0, exp1);
        end
        if (fields == 6) begin
          run_record();
          // Fresh switch value between records
          @(posedge soc_clk);
          rnd = $urandom;
          boot_switch_i <= rnd[BootModeWidth-1:0];
        end
      end
      $fclose(fd);

      $display("tests %0d, errors %0d", chk.test_cnt, chk.err_cnt);
      if (chk.err_cnt == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

endmodule

/* verilog/board_glue_top.sv */
`timescale 1ns/100ps

module board_glue_top (
  input  logic                              soc_clk,
  input  logic                              rst_n,
  input  logic                              dbg_reset_i,
  input  logic [board_pkg::BootModeWidth-1:0] boot_switch_i,
  input  logic [board_pkg::BootModeWidth-1:0] boot_override_i,
  input  logic                              boot_override_sel_i,
  input  logic                              test_mode_i,
  input  logic [board_pkg::FanSetWidth-1:0]   fan_setting_i,
  input  board_pkg::spi_soc_t               spi_soc_i,
  input  board_pkg::i2c_soc_t               i2c_soc_i,
  input  logic                              sd_miso_pad_i,
  input  logic                              scl_pad_i,
  input  logic                              sda_pad_i,
  output logic                              soc_rst_n_o,
  output logic [board_pkg::BootModeWidth-1:0] boot_mode_o,
  output logic                              rtc_o,
  output logic                              fan_pwm_o,
  output board_pkg::sd_pads_t               sd_pads_o,
  output board_pkg::i2c_pads_t              i2c_pads_o,
  output logic [3:0]                        spi_sd_in_o,
  output logic                              i2c_scl_o,
  output logic                              i2c_sda_o
);

  // Synchronized reset for everything behind rst_sync
  logic soc_rst_n;

  ////////////////////////////////////////////////////////////////////////////
  // Reset and boot
  ////////////////////////////////////////////////////////////////////////////

  rst_sync i_rst_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .dbg_reset_i ( dbg_reset_i ),
    .test_mode_i ( test_mode_i ),
    .soc_rst_n_o ( soc_rst_n   )
  );

  assign soc_rst_n_o = soc_rst_n;

  boot_sel i_boot_sel (
    .soc_clk             ( soc_clk             ),
    .rst_n               ( soc_rst_n           ),
    .boot_switch_i       ( boot_switch_i       ),
    .boot_override_i     ( boot_override_i     ),
    .boot_override_sel_i ( boot_override_sel_i ),
    .boot_mode_o         ( boot_mode_o         )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Slow clocks
  ////////////////////////////////////////////////////////////////////////////

  rtc_div i_rtc_div (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  fan_pwm i_fan_pwm (
    .soc_clk       ( soc_clk       ),
    .rst_n         ( soc_rst_n     ),
    .fan_setting_i ( fan_setting_i ),
    .fan_pwm_o     ( fan_pwm_o     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Pads
  ////////////////////////////////////////////////////////////////////////////

  pad_adapt i_pad_adapt (
    .spi_soc_i     ( spi_soc_i     ),
    .i2c_soc_i     ( i2c_soc_i     ),
    .sd_miso_pad_i ( sd_miso_pad_i ),
    .scl_pad_i     ( scl_pad_i     ),
    .sda_pad_i     ( sda_pad_i     ),
    .sd_pads_o     ( sd_pads_o     ),
    .i2c_pads_o    ( i2c_pads_o    ),
    .spi_sd_in_o   ( spi_sd_in_o   ),
    .i2c_scl_o     ( i2c_scl_o     ),
    .i2c_sda_o     ( i2c_sda_o     )
  );

endmodule

/* verilog/board_pkg.sv */
package board_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Timing constants
  ////////////////////////////////////////////////////////////////////////////

  // soc_clk cycles per RTC level, divide by 50 overall
  localparam integer RtcHalfPeriod = 25;
  localparam integer RtcCntWidth   = $clog2(RtcHalfPeriod);

  // Fan setting width, PWM period is 2**FanSetWidth cycles
  localparam integer FanSetWidth = 4;

  // Boot mode straps
  localparam integer BootModeWidth = 2;

  // Flops in the reset release chain
  localparam integer RstSyncStages = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Pad bundles
  ////////////////////////////////////////////////////////////////////////////

  // SPI host outputs as they leave the SoC
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd_out;
    logic [3:0] sd_en;
  } spi_soc_t;

  // Levels driven towards the SD-card socket
  typedef struct packed {
    logic       sclk;
    logic       cmd;
    logic [3:0] dat;
    logic       reset;
  } sd_pads_t;

  // I2C value and enable pairs from the SoC
  typedef struct packed {
    logic scl_out;
    logic scl_en;
    logic sda_out;
    logic sda_en;
  } i2c_soc_t;

  // Open-drain controls, high pulls the line to ground
  typedef struct packed {
    logic scl_pull_low;
    logic sda_pull_low;
  } i2c_pads_t;

endpackage

/* verilog/boot_sel.sv */
`timescale 1ns/100ps

module boot_sel (
  input  logic                            soc_clk,
  input  logic                            rst_n,
  input  logic [board_pkg::BootModeWidth-1:0] boot_switch_i,
  input  logic [board_pkg::BootModeWidth-1:0] boot_override_i,
  input  logic                            boot_override_sel_i,
  output logic [board_pkg::BootModeWidth-1:0] boot_mode_o
);

  import board_pkg::*;

  logic [BootModeWidth-1:0] switch_meta_q;
  logic [BootModeWidth-1:0] switch_sync_q;

  ////////////////////////////////////////////////////////////////////////////
  // Switch synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // Board switches are asynchronous to soc_clk
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      switch_meta_q <= '0;
      switch_sync_q <= '0;
    end else begin
      switch_meta_q <= boot_switch_i;
      switch_sync_q <= switch_meta_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Debug override
  ////////////////////////////////////////////////////////////////////////////

  // Override comes from the debug probe, already in the soc_clk domain
  always_comb begin
    if (boot_override_sel_i) begin
      boot_mode_o = boot_override_i;
    end else begin
      boot_mode_o = switch_sync_q;
    end
  end

endmodule

/* verilog/fan_pwm.sv */
`timescale 1ns/100ps

module fan_pwm (
  input  logic                          soc_clk,
  input  logic                          rst_n,
  input  logic [board_pkg::FanSetWidth-1:0] fan_setting_i,
  output logic                          fan_pwm_o
);

  import board_pkg::*;

  logic [FanSetWidth-1:0] period_cnt_q;
  logic [FanSetWidth-1:0] setting_q;
  logic [FanSetWidth-1:0] setting_cur;
  logic                   period_start;
  logic                   pwm_q;

  ////////////////////////////////////////////////////////////////////////////
  // Period counter
  ////////////////////////////////////////////////////////////////////////////

  // Wraps naturally every 2**FanSetWidth cycles
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt_q <= '0;
    end else begin
      period_cnt_q <= period_cnt_q + 1'b1;
    end
  end

  assign period_start = (period_cnt_q == '0);

  // Switch value is taken once per period
  assign setting_cur = period_start ? fan_setting_i : setting_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      setting_q <= '0;
    end else if (period_start) begin
      setting_q <= fan_setting_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // PWM output
  ////////////////////////////////////////////////////////////////////////////

  // High for the first setting counts of the period, zero stays low
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (period_cnt_q < setting_cur);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

/* verilog/pad_adapt.sv */
`timescale 1ns/100ps

module pad_adapt (
  input  board_pkg::spi_soc_t  spi_soc_i,
  input  board_pkg::i2c_soc_t  i2c_soc_i,
  input  logic                 sd_miso_pad_i,
  input  logic                 scl_pad_i,
  input  logic                 sda_pad_i,
  output board_pkg::sd_pads_t  sd_pads_o,
  output board_pkg::i2c_pads_t i2c_pads_o,
  output logic [3:0]           spi_sd_in_o,
  output logic                 i2c_scl_o,
  output logic                 i2c_sda_o
);

  import board_pkg::*;

  sd_pads_t  sd_pads;
  i2c_pads_t i2c_pads;

  ////////////////////////////////////////////////////////////////////////////
  // SPI onto the SD-card socket
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Reset low keeps the card powered
    sd_pads.reset = 1'b0;
    // Clock idles high while the host releases it
    sd_pads.sclk  = spi_soc_i.sck_en ? spi_soc_i.sck : 1'b1;
    // Chip select 0 sits on DAT3
    sd_pads.dat[3] = spi_soc_i.csb_en[0] ? spi_soc_i.csb[0] : 1'b1;
    // Unused in SPI mode
    sd_pads.dat[2:1] = 2'b11;
    // DAT0 carries MISO from the card, host side stays released
    sd_pads.dat[0] = 1'b1;
    // MOSI goes out on CMD
    sd_pads.cmd = spi_soc_i.sd_en[0] ? spi_soc_i.sd_out[0] : 1'b1;
  end

  // MISO returns on data line 1, the rest are outputs only
  assign spi_sd_in_o = {2'b00, sd_miso_pad_i, 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // I2C open-drain
  ////////////////////////////////////////////////////////////////////////////

  // A driven 1 means release, the pull-up does the rest
  always_comb begin
    i2c_pads.scl_pull_low = i2c_soc_i.scl_en & ~i2c_soc_i.scl_out;
    i2c_pads.sda_pull_low = i2c_soc_i.sda_en & ~i2c_soc_i.sda_out;
  end

  // Read back the wire level, clock stretching shows up here
  assign i2c_scl_o = scl_pad_i;
  assign i2c_sda_o = sda_pad_i;

  assign sd_pads_o  = sd_pads;
  assign i2c_pads_o = i2c_pads;

endmodule

/* verilog/rst_sync.sv */
`timescale 1ns/100ps

module rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic dbg_reset_i,
  input  logic test_mode_i,
  output logic soc_rst_n_o
);

  import board_pkg::*;

  logic                     src_rst_n;
  logic [RstSyncStages-1:0] sync_q;

  // Board button or debugger, either one holds the SoC in reset
  assign src_rst_n = rst_n & ~dbg_reset_i;

  // Assert at once, release through the flop chain
  always_ff @(posedge soc_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[RstSyncStages-2:0], 1'b1};
    end
  end

  // Scan mode hands the board reset straight through
  assign soc_rst_n_o = test_mode_i ? rst_n : sync_q[RstSyncStages-1];

endmodule

/* verilog/rtc_div.sv */
`timescale 1ns/100ps

module rtc_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  import board_pkg::*;

  localparam logic [RtcCntWidth-1:0] CntLast = RtcCntWidth'(RtcHalfPeriod - 1);

  logic [RtcCntWidth-1:0] cnt_d, cnt_q;
  logic                   rtc_d, rtc_q;

  // Count one half period, then flip the level
  always_comb begin
    cnt_d = cnt_q + 1'b1;
    rtc_d = rtc_q;
    if (cnt_q == CntLast) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  // Registered, so the RTC level is glitch free
  assign rtc_o = rtc_q;

endmodule
